/* common/bus_pkg.sv */
package bus_pkg;

    // the data bus is word addressed.
    // The address counts 32-bit words, not bytes.
    typedef logic [31:0] adr_t;

    typedef logic [31:0] dat_t; // one bus data word.

    // one select bit per byte lane of a data word.
    typedef logic [3:0] sel_t;

    typedef logic [7:0] byte_t; // a single byte lane.

    // number of byte lanes in a data word.
    localparam int DAT_BYTES = 4;

endpackage

/* common/soc_map_pkg.sv */
package soc_map_pkg;

    localparam int NUM_SLAVES = 4; // slaves on the data bus, default slave included.

    typedef logic [$clog2(NUM_SLAVES)-1:0] slv_idx_t;

    // slave order is also the decode priority.
    localparam slv_idx_t SLV_RAM     = slv_idx_t'(0);
    localparam slv_idx_t SLV_SEG7    = slv_idx_t'(1);
    localparam slv_idx_t SLV_LED     = slv_idx_t'(2);
    localparam slv_idx_t SLV_DEFAULT = slv_idx_t'(3);

    // the RAM starts at the reset vector.
    // Its base is aligned to 2^16 words, so at most 16 address bits fit below it.
    localparam bus_pkg::adr_t RAM_BASE  = 32'h0001_0000;

    localparam bus_pkg::adr_t SEG7_BASE = 32'h0000_0100; // two registers.
    localparam bus_pkg::adr_t SEG7_MASK = 32'hFFFF_FFFE;

    localparam bus_pkg::adr_t LED_BASE  = 32'h0000_0080; // a single register.
    localparam bus_pkg::adr_t LED_MASK  = 32'hFFFF_FFFF;

    localparam bus_pkg::dat_t DEFAULT_RDATA = 32'hFFFF_FFFF; // read from unmapped space.

    // match mask for a RAM with abits word-address bits.
    function automatic bus_pkg::adr_t ram_mask(input int unsigned abits);
        return ~((bus_pkg::adr_t'(1) << abits) - bus_pkg::adr_t'(1));
    endfunction

endpackage

/* memory/block_ram.sv */
`timescale 1ns/100ps

module block_ram #(
    parameter int unsigned RAM_ABITS = 10
) (
    input  logic                  clk_i,

    input  logic                  a_en_i,
    input  logic                  a_we_i,
    input  bus_pkg::sel_t         a_sel_i,
    input  logic [RAM_ABITS-1:0]  a_adr_i,
    input  bus_pkg::dat_t         a_wdat_i,
    output bus_pkg::dat_t         a_rdat_o,

    input  logic                  b_en_i,
    input  logic [RAM_ABITS-1:0]  b_adr_i,
    output bus_pkg::dat_t         b_rdat_o,
    output logic                  b_ack_o
);

    import bus_pkg::*;

    localparam int unsigned DEPTH = 1 << RAM_ABITS;

    dat_t mem [DEPTH];

    // port A serves the data bus.
    // The read takes the word as it was before this edge's write.
    always_ff @(posedge clk_i) begin
        if (a_en_i) begin
            a_rdat_o <= mem[a_adr_i];
            if (a_we_i) begin
                for (int i = 0; i < DAT_BYTES; i++) begin
                    if (a_sel_i[i]) begin
                        mem[a_adr_i][8*i +: 8] <= a_wdat_i[8*i +: 8];
                    end
                end
            end
        end
    end

    // port B only reads, one instruction word per cycle.
    always_ff @(posedge clk_i) begin
        if (b_en_i) begin
            b_rdat_o <= mem[b_adr_i];
        end
    end

    always_ff @(posedge clk_i) begin
        b_ack_o <= b_en_i; // data on b_rdat_o is valid while this is high.
    end

endmodule

/* seg7/seg7_display.sv */
`timescale 1ns/100ps

module seg7_display #(
    parameter int unsigned SCAN_BITS = 16
) (
    input  logic           clk_i,
    input  logic           rst_n_i,

    input  logic           stb_i,
    input  logic           we_i,
    input  logic           reg_i,
    input  bus_pkg::sel_t  sel_i,
    input  bus_pkg::dat_t  wdat_i,
    output bus_pkg::dat_t  rdat_o,

    output logic [7:0]     seg_o,
    output logic [3:0]     an_o
);

    import bus_pkg::*;

    logic [15:0]          digits_q; // four hex digits, digit 0 in the low nibble.
    byte_t                ctrl_q;   // points in [7:4] and digit enables in [3:0].
    logic [SCAN_BITS-1:0] scan_q;
    logic [1:0]           digit_q;
    logic [3:0]           nibble;
    logic                 dig_en;
    logic                 dig_dp;

    // segments gfedcba for one hex digit.
    // A segment is lit when its bit is low.
    function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0:    return 7'h40;
            4'h1:    return 7'h79;
            4'h2:    return 7'h24;
            4'h3:    return 7'h30;
            4'h4:    return 7'h19;
            4'h5:    return 7'h12;
            4'h6:    return 7'h02;
            4'h7:    return 7'h78;
            4'h8:    return 7'h00;
            4'h9:    return 7'h10;
            4'hA:    return 7'h08;
            4'hB:    return 7'h03;
            4'hC:    return 7'h46;
            4'hD:    return 7'h21;
            4'hE:    return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            digits_q <= '0;
            ctrl_q   <= '0;
        end else if (stb_i && we_i) begin
            if (!reg_i) begin
                if (sel_i[0]) digits_q[7:0]  <= wdat_i[7:0];
                if (sel_i[1]) digits_q[15:8] <= wdat_i[15:8];
            end else if (sel_i[0]) begin
                ctrl_q <= wdat_i[7:0];
            end
        end
    end

    // read data is taken on the strobe and used by the bus one cycle later.
    always_ff @(posedge clk_i) begin
        if (stb_i && !we_i) begin
            rdat_o <= reg_i ? dat_t'(ctrl_q) : dat_t'(digits_q);
        end
    end

    // the digit moves on each time the scan counter wraps.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            scan_q  <= '0;
            digit_q <= '0;
        end else begin
            scan_q <= scan_q + 1'b1;
            if (&scan_q) begin
                digit_q <= digit_q + 1'b1;
            end
        end
    end

    assign nibble = digits_q[4*digit_q +: 4];
    assign dig_en = ctrl_q[digit_q];
    assign dig_dp = ctrl_q[4 + digit_q];

    assign an_o  = dig_en ? ~(4'b0001 << digit_q) : 4'hF;
    assign seg_o = dig_en ? {~dig_dp, hex_to_seg(nibble)} : 8'hFF; // blank when off.

endmodule

/* design/wb_mux.sv */
`timescale 1ns/100ps

module wb_mux #(
    parameter int unsigned RAM_ABITS = 10
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  wbm_cyc_i,
    input  logic                  wbm_stb_i,
    input  logic                  wbm_we_i,
    input  bus_pkg::adr_t         wbm_adr_i,
    input  bus_pkg::sel_t         wbm_sel_i,
    input  bus_pkg::dat_t         wbm_dat_i,
    output bus_pkg::dat_t         wbm_dat_o,
    output logic                  wbm_ack_o,

    output logic                  ram_en_o,
    output logic                  ram_we_o,
    output bus_pkg::sel_t         ram_sel_o,
    output logic [RAM_ABITS-1:0]  ram_adr_o,
    output bus_pkg::dat_t         ram_wdat_o,
    input  bus_pkg::dat_t         ram_rdat_i,

    output logic                  seg_stb_o,
    output logic                  seg_we_o,
    output bus_pkg::sel_t         seg_sel_o,
    output logic                  seg_reg_o,
    output bus_pkg::dat_t         seg_wdat_o,
    input  bus_pkg::dat_t         seg_rdat_i,

    output logic [7:0]            led_o
);

    import bus_pkg::*;
    import soc_map_pkg::*;

    localparam adr_t RAM_MASK = ram_mask(RAM_ABITS);

    logic     pending_q; // set for the ack cycle of a request.
    logic     req;
    slv_idx_t slv_d;
    slv_idx_t slv_q;     // slave that answers the current ack.
    byte_t    led_q;
    logic     led_wr;

    // a request starts on the first cycle of stb with cyc.
    // The cycle after that is the ack cycle and never starts one.
    assign req = wbm_cyc_i & wbm_stb_i & ~pending_q;

    always_comb begin
        if ((wbm_adr_i & RAM_MASK) == RAM_BASE) begin
            slv_d = SLV_RAM;
        end else if ((wbm_adr_i & SEG7_MASK) == SEG7_BASE) begin
            slv_d = SLV_SEG7;
        end else if ((wbm_adr_i & LED_MASK) == LED_BASE) begin
            slv_d = SLV_LED;
        end else begin
            slv_d = SLV_DEFAULT; // nothing matched.
        end
    end

    assign ram_en_o   = req & (slv_d == SLV_RAM);
    assign ram_we_o   = wbm_we_i;
    assign ram_sel_o  = wbm_sel_i;
    assign ram_adr_o  = wbm_adr_i[RAM_ABITS-1:0];
    assign ram_wdat_o = wbm_dat_i;

    assign seg_stb_o  = req & (slv_d == SLV_SEG7);
    assign seg_we_o   = wbm_we_i;
    assign seg_sel_o  = wbm_sel_i;
    assign seg_reg_o  = wbm_adr_i[0];  // register offset inside the display.
    assign seg_wdat_o = wbm_dat_i;

    // only lane 0 of the LED register holds anything.
    assign led_wr = req & wbm_we_i & wbm_sel_i[0] & (slv_d == SLV_LED);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
            slv_q     <= SLV_DEFAULT;
            led_q     <= '0;
        end else begin
            pending_q <= req; // clears again on the ack cycle.
            if (req) begin
                slv_q <= slv_d;
            end
            if (led_wr) begin
                led_q <= wbm_dat_i[7:0];
            end
        end
    end

    assign wbm_ack_o = pending_q;
    assign led_o     = led_q;

    // every slave has its read data ready on the ack cycle.
    always_comb begin
        case (slv_q)
            SLV_RAM:  wbm_dat_o = ram_rdat_i;
            SLV_SEG7: wbm_dat_o = seg_rdat_i;
            SLV_LED:  wbm_dat_o = dat_t'(led_q);
            default:  wbm_dat_o = DEFAULT_RDATA; // the default slave ignores writes.
        endcase
    end

endmodule

/* design/soc_top.sv */
`timescale 1ns/100ps

module soc_top #(
    parameter int unsigned RAM_ABITS = 10,
    parameter int unsigned SCAN_BITS = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  wbm_cyc_i,
    input  logic                  wbm_stb_i,
    input  logic                  wbm_we_i,
    input  bus_pkg::adr_t         wbm_adr_i,
    input  bus_pkg::sel_t         wbm_sel_i,
    input  bus_pkg::dat_t         wbm_dat_i,
    output bus_pkg::dat_t         wbm_dat_o,
    output logic                  wbm_ack_o,

    input  logic                  ifetch_stb_i,
    input  logic [RAM_ABITS-1:0]  ifetch_adr_i,
    output bus_pkg::dat_t         ifetch_dat_o,
    output logic                  ifetch_ack_o,

    output logic [7:0]            led_o,
    output logic [7:0]            seg_o,
    output logic [3:0]            an_o
);

    import bus_pkg::*;

    logic                 ram_en;
    logic                 ram_we;
    sel_t                 ram_sel;
    logic [RAM_ABITS-1:0] ram_adr;
    dat_t                 ram_wdat;
    dat_t                 ram_rdat;

    logic                 seg_stb;
    logic                 seg_we;
    sel_t                 seg_sel;
    logic                 seg_reg;
    dat_t                 seg_wdat;
    dat_t                 seg_rdat;

    wb_mux #(
        .RAM_ABITS  ( RAM_ABITS    )
    ) i_mux (
        .clk_i      ( clk_i        ),
        .rst_n_i    ( rst_n_i      ),
        .wbm_cyc_i  ( wbm_cyc_i    ),
        .wbm_stb_i  ( wbm_stb_i    ),
        .wbm_we_i   ( wbm_we_i     ),
        .wbm_adr_i  ( wbm_adr_i    ),
        .wbm_sel_i  ( wbm_sel_i    ),
        .wbm_dat_i  ( wbm_dat_i    ),
        .wbm_dat_o  ( wbm_dat_o    ),
        .wbm_ack_o  ( wbm_ack_o    ),
        .ram_en_o   ( ram_en       ),
        .ram_we_o   ( ram_we       ),
        .ram_sel_o  ( ram_sel      ),
        .ram_adr_o  ( ram_adr      ),
        .ram_wdat_o ( ram_wdat     ),
        .ram_rdat_i ( ram_rdat     ),
        .seg_stb_o  ( seg_stb      ),
        .seg_we_o   ( seg_we       ),
        .seg_sel_o  ( seg_sel      ),
        .seg_reg_o  ( seg_reg      ),
        .seg_wdat_o ( seg_wdat     ),
        .seg_rdat_i ( seg_rdat     ),
        .led_o      ( led_o        )
    );

    // port B of the RAM is the instruction fetch path.
    block_ram #(
        .RAM_ABITS  ( RAM_ABITS    )
    ) i_ram (
        .clk_i      ( clk_i        ),
        .a_en_i     ( ram_en       ),
        .a_we_i     ( ram_we       ),
        .a_sel_i    ( ram_sel      ),
        .a_adr_i    ( ram_adr      ),
        .a_wdat_i   ( ram_wdat     ),
        .a_rdat_o   ( ram_rdat     ),
        .b_en_i     ( ifetch_stb_i ),
        .b_adr_i    ( ifetch_adr_i ),
        .b_rdat_o   ( ifetch_dat_o ),
        .b_ack_o    ( ifetch_ack_o )
    );

    seg7_display #(
        .SCAN_BITS  ( SCAN_BITS    )
    ) i_seg7 (
        .clk_i      ( clk_i        ),
        .rst_n_i    ( rst_n_i      ),
        .stb_i      ( seg_stb      ),
        .we_i       ( seg_we       ),
        .reg_i      ( seg_reg      ),
        .sel_i      ( seg_sel      ),
        .wdat_i     ( seg_wdat     ),
        .rdat_o     ( seg_rdat     ),
        .seg_o      ( seg_o        ),
        .an_o       ( an_o         )
    );

endmodule

/* verif/tb_soc.sv */
`timescale 1ns/100ps

module tb_soc;

    import bus_pkg::*;
    import soc_map_pkg::*;

    localparam int unsigned RAM_ABITS = 10;
    localparam int unsigned SCAN_BITS = 4;
    localparam int unsigned SEED      = 32'he2491bb6;

    localparam int RAM_WORDS    = 1 << RAM_ABITS;
    localparam int RAM_TESTS    = 300;
    localparam int FETCH_TESTS  = 200;
    localparam int MISC_TESTS   = 20;
    localparam int WATCH_CYCLES = 16 << SCAN_BITS; // four rounds give 64 scan periods.

    // every bus access takes two cycles and each display round adds its watch time.
    localparam int RUN_CYCLES = 2 * RAM_WORDS + 4 * RAM_TESTS + FETCH_TESTS
                              + 8 * MISC_TESTS + 4 * (12 + WATCH_CYCLES) + 64;
    localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

    logic                 clk;
    logic                 rst_n;
    logic                 wbm_cyc;
    logic                 wbm_stb;
    logic                 wbm_we;
    adr_t                 wbm_adr;
    sel_t                 wbm_sel;
    dat_t                 wbm_dat;
    dat_t                 wbm_dat_o;
    logic                 wbm_ack;
    logic                 ifetch_stb;
    logic [RAM_ABITS-1:0] ifetch_adr;
    dat_t                 ifetch_dat;
    logic                 ifetch_ack;
    logic [7:0]           led;
    logic [7:0]           seg;
    logic [3:0]           an;

    // reference model of everything the bus can write.
    dat_t        ram_m [RAM_WORDS];
    byte_t       led_m;
    logic [15:0] digits_m;
    byte_t       ctrl_m;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    soc_top #(
        .RAM_ABITS    ( RAM_ABITS  ),
        .SCAN_BITS    ( SCAN_BITS  )
    ) i_dut (
        .clk_i        ( clk        ),
        .rst_n_i      ( rst_n      ),
        .wbm_cyc_i    ( wbm_cyc    ),
        .wbm_stb_i    ( wbm_stb    ),
        .wbm_we_i     ( wbm_we     ),
        .wbm_adr_i    ( wbm_adr    ),
        .wbm_sel_i    ( wbm_sel    ),
        .wbm_dat_i    ( wbm_dat    ),
        .wbm_dat_o    ( wbm_dat_o  ),
        .wbm_ack_o    ( wbm_ack    ),
        .ifetch_stb_i ( ifetch_stb ),
        .ifetch_adr_i ( ifetch_adr ),
        .ifetch_dat_o ( ifetch_dat ),
        .ifetch_ack_o ( ifetch_ack ),
        .led_o        ( led        ),
        .seg_o        ( seg        ),
        .an_o         ( an         )
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_val(input string test, input dat_t exp, input dat_t act);
        checks++;
        assert (act === exp) else begin
            $display("ERR %s: expected %h, actual %h", test, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string test, input logic ok, input string what);
        checks++;
        assert (ok === 1'b1) else begin
            $display("error in %s: %s", test, what);
            errors++;
        end
    endtask

    // lit segments gfedcba of a hex digit, a one for each lit segment.
    function automatic logic [6:0] lit_segments(input logic [3:0] nib);
        logic [6:0] table_v [16];
        table_v = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                    7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
        return table_v[nib];
    endfunction

    function automatic dat_t merge_lanes(input dat_t old, input dat_t wdat, input sel_t sel);
        dat_t res = old;
        for (int i = 0; i < DAT_BYTES; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = wdat[8*i +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic is_mapped(input adr_t a);
        return ((a >> RAM_ABITS) == (RAM_BASE >> RAM_ABITS))
            || ((a >> 1) == (SEG7_BASE >> 1)) || (a == LED_BASE);
    endfunction

    function automatic adr_t random_unmapped();
        adr_t a;
        do begin
            a = $urandom;
            if (1'($urandom)) begin
                a &= 32'h0000_01FF; // stay close to the device registers.
            end
        end while (is_mapped(a));
        return a;
    endfunction

    // one data bus request, started just after a rising edge.
    // With hold set, stb stays high through the ack cycle.
    task automatic bus_access(input string test, input logic we, input adr_t adr,
                              input sel_t sel, input dat_t wdat, input logic hold,
                              output dat_t rdat);
        check_flag(test, wbm_ack === 1'b0, "acknowledge was high before the request");
        wbm_cyc = 1'b1;
        wbm_stb = 1'b1;
        wbm_we  = we;
        wbm_adr = adr;
        wbm_sel = sel;
        wbm_dat = wdat;
        @(posedge clk);
        #1;
        check_flag(test, wbm_ack === 1'b1, "no acknowledge one cycle after the request");
        rdat = wbm_dat_o;
        if (!hold) begin
            wbm_cyc = 1'b0;
            wbm_stb = 1'b0;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic bus_idle();
        wbm_cyc = 1'b0;
        wbm_stb = 1'b0;
    endtask

    task automatic ram_write(input int idx, input sel_t sel, input dat_t wdat,
                             input logic hold);
        dat_t rd;
        bus_access("ram write", 1'b1, RAM_BASE | adr_t'(idx), sel, wdat, hold, rd);
        ram_m[idx] = merge_lanes(ram_m[idx], wdat, sel);
    endtask

    task automatic ram_read(input int idx, input logic hold);
        dat_t rd;
        bus_access("ram read", 1'b0, RAM_BASE | adr_t'(idx), 4'hF, '0, hold, rd);
        check_val("ram read", ram_m[idx], rd);
    endtask

    task automatic read_display_regs();
        dat_t rd;
        bus_access("display read", 1'b0, SEG7_BASE, 4'hF, '0, 1'b0, rd);
        check_val("display digits read", dat_t'(digits_m), rd);
        bus_access("display read", 1'b0, SEG7_BASE + 1, 4'hF, '0, 1'b0, rd);
        check_val("display control read", dat_t'(ctrl_m), rd);
    endtask

    task automatic watch_display(input int ncycles);
        int          lows;
        int          d;
        logic [3:0]  seen;
        logic [7:0]  exp;
        seen = '0;
        for (int c = 0; c < ncycles; c++) begin
            @(posedge clk);
            #1;
            lows = 0;
            d = 0;
            for (int k = 0; k < 4; k++) begin
                if (an[k] !== 1'b1) begin
                    lows++;
                    d = k;
                end
            end
            check_flag("display", lows <= 1, "more than one anode is low");
            if (lows == 1) begin
                check_flag("display", ctrl_m[d] === 1'b1, "an anode is low on a disabled digit");
                exp = {~ctrl_m[4+d], ~lit_segments(digits_m[4*d +: 4])};
                check_val("display segments", dat_t'(exp), dat_t'(seg));
                seen[d] = 1'b1;
            end else begin
                check_val("display blank", dat_t'(8'hFF), dat_t'(seg));
            end
        end
        check_val("digits scanned", dat_t'(ctrl_m[3:0]), dat_t'(seen)); // all enabled ones.
    endtask

    initial begin
        dat_t rd;
        dat_t wdat;
        sel_t sel;
        adr_t adr;
        int   idx;

        void'($urandom(SEED));
        clk        = 1'b0;
        rst_n      = 1'b0;
        wbm_cyc    = 1'b0;
        wbm_stb    = 1'b0;
        wbm_we     = 1'b0;
        wbm_adr    = '0;
        wbm_sel    = '0;
        wbm_dat    = '0;
        ifetch_stb = 1'b0;
        ifetch_adr = '0;
        led_m      = '0;
        digits_m   = '0;
        ctrl_m     = '0;

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_val("reset ack", '0, dat_t'(wbm_ack));
        check_val("reset fetch ack", '0, dat_t'(ifetch_ack));
        check_val("reset led", '0, dat_t'(led));
        check_val("reset anodes", dat_t'(4'hF), dat_t'(an));
        check_val("reset segments", dat_t'(8'hFF), dat_t'(seg));

        // fill the whole RAM back to back, stb held high between requests.
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_write(i, 4'hF, $urandom, i != RAM_WORDS - 1);
        end
        bus_idle();

        for (int n = 0; n < RAM_TESTS; n++) begin
            idx = $urandom_range(RAM_WORDS - 1, 0);
            ram_write(idx, sel_t'($urandom), $urandom, 1'($urandom));
            if ($urandom_range(1, 0) == 1) begin
                ram_read(idx, 1'($urandom));
            end else begin
                ram_read($urandom_range(RAM_WORDS - 1, 0), 1'($urandom));
            end
        end
        bus_idle();

        // one fetch per cycle, each checked on the edge after it was issued.
        for (int n = 0; n < FETCH_TESTS; n++) begin
            idx = $urandom_range(RAM_WORDS - 1, 0);
            ifetch_stb = 1'b1;
            ifetch_adr = idx[RAM_ABITS-1:0];
            @(posedge clk);
            #1;
            check_flag("fetch", ifetch_ack === 1'b1, "no fetch acknowledge after the request");
            check_val("fetch", ram_m[idx], ifetch_dat);
        end
        ifetch_stb = 1'b0;
        @(posedge clk);
        #1;
        check_flag("fetch", ifetch_ack === 1'b0, "fetch acknowledge stayed high without a request");

        for (int n = 0; n < MISC_TESTS; n++) begin
            wdat = $urandom;
            sel  = sel_t'($urandom);
            bus_access("led write", 1'b1, LED_BASE, sel, wdat, 1'b0, rd);
            led_m = 8'(merge_lanes(dat_t'(led_m), wdat, sel & 4'b0001));
            check_val("led output", dat_t'(led_m), dat_t'(led));
            bus_access("led read", 1'b0, LED_BASE, 4'hF, '0, 1'b0, rd);
            check_val("led read", dat_t'(led_m), rd);
        end

        for (int n = 0; n < MISC_TESTS; n++) begin
            adr = random_unmapped();
            bus_access("unmapped write", 1'b1, adr, 4'hF, $urandom, 1'b0, rd);
            bus_access("unmapped read", 1'b0, adr, 4'hF, '0, 1'b0, rd);
            check_val("unmapped read", DEFAULT_RDATA, rd);
            check_val("led after unmapped write", dat_t'(led_m), dat_t'(led));
        end
        read_display_regs();
        ram_read($urandom_range(RAM_WORDS - 1, 0), 1'b0);

        for (int r = 0; r < 4; r++) begin
            wdat = $urandom;
            sel  = sel_t'($urandom);
            bus_access("display write", 1'b1, SEG7_BASE, sel, wdat, 1'b0, rd);
            digits_m = 16'(merge_lanes(dat_t'(digits_m), wdat, sel & 4'b0011));
            wdat = $urandom;
            sel  = sel_t'($urandom) | 4'b0001; // the control lane is always written.
            bus_access("display write", 1'b1, SEG7_BASE + 1, sel, wdat, 1'b0, rd);
            ctrl_m = 8'(merge_lanes(dat_t'(ctrl_m), wdat, sel & 4'b0001));
            read_display_regs();
            watch_display(WATCH_CYCLES);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tb.f */
common/bus_pkg.sv
common/soc_map_pkg.sv
memory/block_ram.sv
seg7/seg7_display.sv
design/wb_mux.sv
design/soc_top.sv
verif/tb_soc.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_soc \
    -f tb.f \
    --Mdir obj_dir \
    -o tb_soc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_soc_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run passes only if the testbench printed its pass line.
if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1
